// File: include/mips_config.svh
/* Encodings for the supported MIPS subset only. Memory depths are in 32-bit words
   and must be powers of two. */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Primary opcodes
`define OP_RTYPE   6'd0
`define OP_J       6'd2
`define OP_JAL     6'd3
`define OP_BNE     6'd5
`define OP_XORI    6'd14
`define OP_LW      6'd35
`define OP_SW      6'd43

// Funct codes, valid only with OP_RTYPE
`define FN_JR      6'd8
`define FN_ADD     6'd32
`define FN_SUB     6'd34
`define FN_SLT     6'd42

`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

`define LINK_REG   5'd31    // JAL destination

`endif

// File: logic/mipsPkg.sv
/* Shared types for the single-cycle core. ALU op encodings are fixed
   3-bit codes. */
package mipsPkg;

    typedef logic [31:0] wordT;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_XOR  = 3'd2,
        ALU_SLT  = 3'd3,
        ALU_AND  = 3'd4,
        ALU_NAND = 3'd5,
        ALU_NOR  = 3'd6,
        ALU_OR   = 3'd7
    } aluOpT;

    // Destination register select
    typedef enum logic [1:0] {
        WR_RT   = 2'd0,
        WR_RD   = 2'd1,
        WR_LINK = 2'd2
    } wrAddrSelT;

    typedef enum logic [1:0] {
        WB_MEM     = 2'd0,
        WB_ALU     = 2'd1,
        WB_PCPLUS4 = 2'd2  // Link value for JAL
    } wbSrcSelT;

endpackage

// File: logic/controlDecoder.sv
/* Unknown opcodes and functs give an all-inactive control word, so the
   core treats them as a no-op that advances the PC by 4. */
`timescale 1ns/1ns
`include "mips_config.svh"

module opcodeTable (
    input  logic [5:0]          opcode,
    output logic                regWrEn,
    output logic                memWrEn,
    output mipsPkg::wrAddrSelT  wrAddrSel,
    output logic                aluSrcReg,
    output mipsPkg::aluOpT      aluOp,
    output mipsPkg::wbSrcSelT   wbSrc,
    output logic                jumpReg,
    output logic                jumpTarget,
    output logic                branch
);
    import mipsPkg::*;

    always_comb begin
        regWrEn    = 1'b0;
        memWrEn    = 1'b0;
        wrAddrSel  = WR_RT;
        aluSrcReg  = 1'b0;      // Immediate operand
        aluOp      = ALU_ADD;
        wbSrc      = WB_MEM;
        jumpReg    = 1'b0;
        jumpTarget = 1'b0;
        branch     = 1'b0;
        case (opcode)
            `OP_J: begin
                jumpTarget = 1'b1;
            end
            `OP_JAL: begin
                regWrEn    = 1'b1;
                wrAddrSel  = WR_LINK;
                wbSrc      = WB_PCPLUS4;
                jumpTarget = 1'b1;
            end
            `OP_BNE: begin
                aluSrcReg = 1'b1;
                aluOp     = ALU_SUB;   // Nonzero means not equal
                branch    = 1'b1;
            end
            `OP_XORI: begin
                regWrEn = 1'b1;
                aluOp   = ALU_XOR;
                wbSrc   = WB_ALU;
            end
            `OP_LW:  regWrEn = 1'b1;
            `OP_SW:  memWrEn = 1'b1;
            default: ;
        endcase
    end

endmodule

module functTable (
    input  logic [5:0]          funct,
    output logic                regWrEn,
    output logic                memWrEn,
    output mipsPkg::wrAddrSelT  wrAddrSel,
    output logic                aluSrcReg,
    output mipsPkg::aluOpT      aluOp,
    output mipsPkg::wbSrcSelT   wbSrc,
    output logic                jumpReg,
    output logic                jumpTarget,
    output logic                branch
);
    import mipsPkg::*;

    always_comb begin
        regWrEn    = 1'b0;
        memWrEn    = 1'b0;
        wrAddrSel  = WR_RD;
        aluSrcReg  = 1'b1;
        aluOp      = ALU_ADD;
        wbSrc      = WB_ALU;
        jumpReg    = 1'b0;
        jumpTarget = 1'b0;
        branch     = 1'b0;
        case (funct)
            `FN_JR:  jumpReg = 1'b1;
            `FN_ADD: regWrEn = 1'b1;
            `FN_SUB: begin
                regWrEn = 1'b1;
                aluOp   = ALU_SUB;
            end
            `FN_SLT: begin
                regWrEn = 1'b1;
                aluOp   = ALU_SLT;
            end
            default: ;
        endcase
    end

endmodule

module controlDecoder (
    input  logic [5:0]          opcode,
    input  logic [5:0]          funct,
    output logic                regWrEn,
    output logic                memWrEn,
    output mipsPkg::wrAddrSelT  wrAddrSel,
    output logic                aluSrcReg,
    output mipsPkg::aluOpT      aluOp,
    output mipsPkg::wbSrcSelT   wbSrc,
    output logic                jumpReg,
    output logic                jumpTarget,
    output logic                branch
);
    import mipsPkg::*;

    logic      opRegWrEn, opMemWrEn, opAluSrcReg, opJumpReg, opJumpTarget, opBranch;
    logic      fnRegWrEn, fnMemWrEn, fnAluSrcReg, fnJumpReg, fnJumpTarget, fnBranch;
    wrAddrSelT opWrAddrSel, fnWrAddrSel;
    aluOpT     opAluOp, fnAluOp;
    wbSrcSelT  opWbSrc, fnWbSrc;

    opcodeTable opTable (
        .opcode(opcode), .regWrEn(opRegWrEn), .memWrEn(opMemWrEn),
        .wrAddrSel(opWrAddrSel), .aluSrcReg(opAluSrcReg), .aluOp(opAluOp),
        .wbSrc(opWbSrc), .jumpReg(opJumpReg), .jumpTarget(opJumpTarget), .branch(opBranch)
    );

    functTable fnTable (
        .funct(funct), .regWrEn(fnRegWrEn), .memWrEn(fnMemWrEn),
        .wrAddrSel(fnWrAddrSel), .aluSrcReg(fnAluSrcReg), .aluOp(fnAluOp),
        .wbSrc(fnWbSrc), .jumpReg(fnJumpReg), .jumpTarget(fnJumpTarget), .branch(fnBranch)
    );

    // R-type takes its control word from the funct table
    always_comb begin
        if (opcode == `OP_RTYPE) begin
            regWrEn    = fnRegWrEn;
            memWrEn    = fnMemWrEn;
            wrAddrSel  = fnWrAddrSel;
            aluSrcReg  = fnAluSrcReg;
            aluOp      = fnAluOp;
            wbSrc      = fnWbSrc;
            jumpReg    = fnJumpReg;
            jumpTarget = fnJumpTarget;
            branch     = fnBranch;
        end else begin
            regWrEn    = opRegWrEn;
            memWrEn    = opMemWrEn;
            wrAddrSel  = opWrAddrSel;
            aluSrcReg  = opAluSrcReg;
            aluOp      = opAluOp;
            wbSrc      = opWbSrc;
            jumpReg    = opJumpReg;
            jumpTarget = opJumpTarget;
            branch     = opBranch;
        end
    end

endmodule

// File: logic/alu.sv
/* Purely combinational, no flags or overflow trap. SLT compares signed. */
`timescale 1ns/1ns

module alu (
    input  mipsPkg::wordT  a,
    input  mipsPkg::wordT  b,
    input  mipsPkg::aluOpT op,
    output mipsPkg::wordT  result
);
    import mipsPkg::*;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;   // Also the BNE compare
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            ALU_AND:  result = a & b;
            ALU_NAND: result = ~(a & b);
            ALU_NOR:  result = ~(a | b);
            ALU_OR:   result = a | b;
            default:  result = a + b;
        endcase
    end

endmodule

// File: logic/regFile.sv
/* Register 0 reads zero whatever was written. Writes are ignored while
   rstN is low, and reset clears every register. */
`timescale 1ns/1ns

module regFile (
    input  logic          clk,
    input  logic          rstN,
    input  logic [4:0]    rdAddrA,
    input  logic [4:0]    rdAddrB,
    input  logic          wrEn,
    input  logic [4:0]    wrAddr,
    input  mipsPkg::wordT wrData,
    output mipsPkg::wordT rdDataA,
    output mipsPkg::wordT rdDataB
);
    import mipsPkg::*;

    wordT regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Asynchronous reads
    assign rdDataA = (rdAddrA == 5'd0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == 5'd0) ? '0 : regs[rdAddrB];

endmodule

// File: logic/wordMemory.sv
/* Word addressed, asynchronous read, one synchronous write port. Contents
   are undefined until written. */
`timescale 1ns/1ns

module wordMemory #(
    parameter type dataT = logic [31:0],
    parameter int  DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     wrEn,
    input  logic [$clog2(DEPTH)-1:0] wrAddr,
    input  logic [$clog2(DEPTH)-1:0] rdAddr,
    input  dataT                     wrData,
    output dataT                     rdData
);

    dataT mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    assign rdData = mem[rdAddr];

endmodule

// File: logic/mipsCore.sv
/* Single-cycle core, one instruction per clock, no delay slots. Load the
   program through progWrEn only while rstN is low. */
`timescale 1ns/1ns
`include "mips_config.svh"

module mipsCore (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            progWrEn,
    input  logic [$clog2(`IMEM_DEPTH)-1:0]  progAddr,
    input  mipsPkg::wordT                   progData,
    output mipsPkg::wordT                   pc,
    output logic                            regWrEn,
    output logic [4:0]                      regWrAddr,
    output mipsPkg::wordT                   regWrData,
    output logic                            memWrEn,
    output mipsPkg::wordT                   memAddr,
    output mipsPkg::wordT                   memWrData
);
    import mipsPkg::*;

    localparam int IMEM_AW = $clog2(`IMEM_DEPTH);
    localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

    wordT      instr, pcPlus4, nextPc, immExt, aluB, aluResult, rsData, rtData, memRdData;
    logic      decRegWrEn, decMemWrEn, aluSrcReg, jumpReg, jumpTarget, branch;
    wrAddrSelT wrAddrSel;
    aluOpT     aluOp;
    wbSrcSelT  wbSrc;

    logic [5:0]  opcode, funct;
    logic [4:0]  rs, rt, rd;
    logic [15:0] imm;
    logic [25:0] target;

    // Loader owns the instruction memory during reset
    wordMemory #(.dataT(wordT), .DEPTH(`IMEM_DEPTH)) imem (
        .clk(clk), .wrEn(progWrEn && !rstN), .wrAddr(progAddr),
        .rdAddr(pc[IMEM_AW+1:2]), .wrData(progData), .rdData(instr)
    );

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];
    assign target = instr[25:0];

    controlDecoder decoder (
        .opcode(opcode), .funct(funct), .regWrEn(decRegWrEn), .memWrEn(decMemWrEn),
        .wrAddrSel(wrAddrSel), .aluSrcReg(aluSrcReg), .aluOp(aluOp), .wbSrc(wbSrc),
        .jumpReg(jumpReg), .jumpTarget(jumpTarget), .branch(branch)
    );

    regFile regs (
        .clk(clk), .rstN(rstN), .rdAddrA(rs), .rdAddrB(rt), .wrEn(regWrEn),
        .wrAddr(regWrAddr), .wrData(regWrData), .rdDataA(rsData), .rdDataB(rtData)
    );

    // XORI zero-extends, the rest sign-extend
    assign immExt = (opcode == `OP_XORI) ? {16'd0, imm} : {{16{imm[15]}}, imm};
    assign aluB   = aluSrcReg ? rtData : immExt;

    alu alu0 (.a(rsData), .b(aluB), .op(aluOp), .result(aluResult));

    wordMemory #(.dataT(wordT), .DEPTH(`DMEM_DEPTH)) dmem (
        .clk(clk), .wrEn(memWrEn), .wrAddr(aluResult[DMEM_AW+1:2]),
        .rdAddr(aluResult[DMEM_AW+1:2]), .wrData(rtData), .rdData(memRdData)
    );

    always_comb begin
        case (wrAddrSel)
            WR_RD:   regWrAddr = rd;
            WR_LINK: regWrAddr = `LINK_REG;
            default: regWrAddr = rt;
        endcase
        case (wbSrc)
            WB_ALU:     regWrData = aluResult;
            WB_PCPLUS4: regWrData = pcPlus4;
            default:    regWrData = memRdData;
        endcase
    end

    // No architectural writes while in reset
    assign regWrEn   = decRegWrEn && rstN;
    assign memWrEn   = decMemWrEn && rstN;
    assign memAddr   = aluResult;
    assign memWrData = rtData;

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        if (jumpReg) begin
            nextPc = rsData;
        end else if (jumpTarget) begin
            nextPc = {pcPlus4[31:28], target, 2'b00};
        end else if (branch && aluResult != '0) begin
            nextPc = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// File: bench/mipsCore_sva.sv
/* Compares retired effects with the reference model. Address and data
   are only checked when the matching write enable is expected. */
`timescale 1ns/1ns

module mipsCoreChecker (
    input  logic          clk,
    input  logic          rstN,
    input  mipsPkg::wordT pc,
    input  logic          regWrEn,
    input  logic [4:0]    regWrAddr,
    input  mipsPkg::wordT regWrData,
    input  logic          memWrEn,
    input  mipsPkg::wordT memAddr,
    input  mipsPkg::wordT memWrData,
    input  mipsPkg::wordT expPc,
    input  logic          expRegWrEn,
    input  logic [4:0]    expRegWrAddr,
    input  mipsPkg::wordT expRegWrData,
    input  logic          expMemWrEn,
    input  mipsPkg::wordT expMemAddr,
    input  mipsPkg::wordT expMemWrData
);

    int errorCount = 0;     // Read by the testbench summary

    pcMatch: assert property (@(posedge clk) disable iff (!rstN) pc == expPc)
        else begin
            errorCount = errorCount + 1;
            $error("Mismatch at %0t: pc expected %h actual %h",
                   $time, $sampled(expPc), $sampled(pc));
        end

    regEnMatch: assert property (@(posedge clk) disable iff (!rstN) regWrEn == expRegWrEn)
        else begin
            errorCount = errorCount + 1;
            $error("Mismatch at %0t: regWrEn expected %b actual %b",
                   $time, $sampled(expRegWrEn), $sampled(regWrEn));
        end

    regAddrMatch: assert property (@(posedge clk) disable iff (!rstN)
                                   expRegWrEn |-> regWrAddr == expRegWrAddr)
        else begin
            errorCount = errorCount + 1;
            $error("Mismatch at %0t: regWrAddr expected %0d actual %0d",
                   $time, $sampled(expRegWrAddr), $sampled(regWrAddr));
        end

    regDataMatch: assert property (@(posedge clk) disable iff (!rstN)
                                   expRegWrEn |-> regWrData == expRegWrData)
        else begin
            errorCount = errorCount + 1;
            $error("Mismatch at %0t: regWrData expected %h actual %h",
                   $time, $sampled(expRegWrData), $sampled(regWrData));
        end

    memEnMatch: assert property (@(posedge clk) disable iff (!rstN) memWrEn == expMemWrEn)
        else begin
            errorCount = errorCount + 1;
            $error("Mismatch at %0t: memWrEn expected %b actual %b",
                   $time, $sampled(expMemWrEn), $sampled(memWrEn));
        end

    memAddrMatch: assert property (@(posedge clk) disable iff (!rstN)
                                   expMemWrEn |-> memAddr == expMemAddr)
        else begin
            errorCount = errorCount + 1;
            $error("Mismatch at %0t: memAddr expected %h actual %h",
                   $time, $sampled(expMemAddr), $sampled(memAddr));
        end

    memDataMatch: assert property (@(posedge clk) disable iff (!rstN)
                                   expMemWrEn |-> memWrData == expMemWrData)
        else begin
            errorCount = errorCount + 1;
            $error("Mismatch at %0t: memWrData expected %h actual %h",
                   $time, $sampled(expMemWrData), $sampled(memWrData));
        end

    // Nothing may be written while reset is low
    resetQuiet: assert property (@(posedge clk) !rstN |-> !regWrEn && !memWrEn)
        else begin
            errorCount = errorCount + 1;
            $error("A write enable was active at %0t while reset was asserted", $time);
        end

    resetPc: assert property (@(posedge clk) !rstN |=> pc == 32'd0)
        else begin
            errorCount = errorCount + 1;
            $error("Mismatch at %0t: pc expected 00000000 actual %h", $time, $sampled(pc));
        end

endmodule

// File: bench/mipsCore_tb.sv
/* Program is built from random operands at run time and loaded while reset
   is low. Reset stays low for 8 more cycles once the load is done. */
`timescale 1ns/1ns
`include "mips_config.svh"

module mipsCore_tb;
    import mipsPkg::*;

    localparam int IAW           = $clog2(`IMEM_DEPTH);
    localparam int DAW           = $clog2(`DMEM_DEPTH);
    localparam int PROG_LEN      = 30;
    localparam int RESET_CYCLES  = 8;
    localparam int CLK_PERIOD    = 40;
    localparam int LOOP_PC       = 29 * 4;   // J-to-self at the end
    localparam int WATCHDOG_CYCLES = PROG_LEN + RESET_CYCLES + PROG_LEN * 3;

    logic           clk = 1'b0;
    logic           rstN;
    logic           progWrEn;
    logic [IAW-1:0] progAddr;
    wordT           progData;
    wordT           pc, regWrData, memAddr, memWrData;
    logic           regWrEn, memWrEn;
    logic [4:0]     regWrAddr;

    // Reference model state
    wordT prog [`IMEM_DEPTH];
    wordT mRegs [32];
    wordT mMem [`DMEM_DEPTH];
    wordT mPc;
    int   retired = 0;

    wordT       expPc, expRegWrData, expMemAddr, expMemWrData, expNextPc;
    logic       expRegWrEn, expMemWrEn;
    logic [4:0] expRegWrAddr;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mipsCore DUT (
        .clk(clk), .rstN(rstN), .progWrEn(progWrEn), .progAddr(progAddr),
        .progData(progData), .pc(pc), .regWrEn(regWrEn), .regWrAddr(regWrAddr),
        .regWrData(regWrData), .memWrEn(memWrEn), .memAddr(memAddr), .memWrData(memWrData)
    );

    bind mipsCore mipsCoreChecker chk (
        .clk(clk), .rstN(rstN), .pc(pc), .regWrEn(regWrEn), .regWrAddr(regWrAddr),
        .regWrData(regWrData), .memWrEn(memWrEn), .memAddr(memAddr), .memWrData(memWrData),
        .expPc(mipsCore_tb.expPc), .expRegWrEn(mipsCore_tb.expRegWrEn),
        .expRegWrAddr(mipsCore_tb.expRegWrAddr), .expRegWrData(mipsCore_tb.expRegWrData),
        .expMemWrEn(mipsCore_tb.expMemWrEn), .expMemAddr(mipsCore_tb.expMemAddr),
        .expMemWrData(mipsCore_tb.expMemWrData)
    );

    function automatic wordT encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                     input logic [4:0] rd, input logic [5:0] funct);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic wordT encodeI(input logic [5:0] op, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT encodeJ(input logic [5:0] op, input logic [25:0] target);
        return {op, target};
    endfunction

    task automatic buildProgram();
        logic [15:0] rndA, rndB, rndC;
        rndA = 16'($urandom()) | 16'h8000;   // Keeps r1 above r2
        rndB = 16'($urandom());
        rndC = 16'($urandom());
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            prog[i] = encodeJ(`OP_J, 26'(i));      // Every word jumps to itself
        end
        prog[0]  = encodeI(`OP_XORI, 5'd0, 5'd1, rndA);
        prog[1]  = encodeR(5'd1, 5'd1, 5'd1, `FN_ADD);   // Shift left via doubling
        prog[2]  = encodeR(5'd1, 5'd1, 5'd1, `FN_ADD);
        prog[3]  = encodeR(5'd1, 5'd1, 5'd1, `FN_ADD);
        prog[4]  = encodeI(`OP_XORI, 5'd1, 5'd1, rndB);
        prog[5]  = encodeI(`OP_XORI, 5'd0, 5'd2, rndC);
        prog[6]  = encodeR(5'd2, 5'd2, 5'd2, `FN_ADD);
        prog[7]  = encodeR(5'd1, 5'd2, 5'd3, `FN_ADD);
        prog[8]  = encodeR(5'd2, 5'd1, 5'd4, `FN_SUB);   // Negative
        prog[9]  = encodeR(5'd4, 5'd0, 5'd5, `FN_SLT);
        prog[10] = encodeR(5'd1, 5'd2, 5'd6, `FN_SLT);
        prog[11] = encodeR(5'd1, 5'd2, 5'd0, `FN_ADD);   // Write to r0
        prog[12] = encodeR(5'd0, 5'd0, 5'd7, `FN_ADD);
        prog[13] = encodeI(`OP_XORI, 5'd0, 5'd8, 16'h0040);
        prog[14] = encodeI(`OP_SW, 5'd8, 5'd3, 16'h0000);
        prog[15] = encodeI(`OP_SW, 5'd8, 5'd4, 16'hfffc);
        prog[16] = encodeI(`OP_LW, 5'd8, 5'd9, 16'h0000);
        prog[17] = encodeI(`OP_LW, 5'd8, 5'd10, 16'hfffc);
        prog[18] = encodeI(`OP_BNE, 5'd8, 5'd0, 16'd1);  // Taken
        prog[19] = encodeI(`OP_XORI, 5'd0, 5'd11, 16'hdead);
        prog[20] = encodeI(`OP_BNE, 5'd1, 5'd1, 16'd5);  // Not taken
        prog[21] = encodeJ(`OP_JAL, 26'd24);
        prog[22] = encodeJ(`OP_J, 26'd27);
        prog[23] = encodeI(`OP_XORI, 5'd0, 5'd14, 16'hbeef);
        prog[24] = encodeI(6'd63, 5'd1, 5'd2, 16'h1234); // Unlisted opcode
        prog[25] = encodeR(5'd1, 5'd2, 5'd3, 6'd1);      // Unlisted funct
        prog[26] = encodeR(5'd31, 5'd0, 5'd0, `FN_JR);
        prog[27] = encodeI(`OP_XORI, 5'd31, 5'd12, 16'h0001);
        prog[28] = encodeR(5'd2, 5'd1, 5'd13, `FN_SLT);
        prog[29] = encodeJ(`OP_J, 26'd29);
    endtask

    task automatic loadProgram();
        for (int i = 0; i < PROG_LEN; i++) begin
            @(negedge clk);
            progWrEn = 1'b1;
            progAddr = IAW'(i);
            progData = prog[i];
        end
        @(negedge clk);
        progWrEn = 1'b0;
    endtask

    // Expected effects of the instruction at the model PC
    always_comb begin
        wordT instr, rsV, rtV, sImm, pcPlus4;
        instr   = prog[mPc[IAW+1:2]];
        rsV     = mRegs[instr[25:21]];
        rtV     = mRegs[instr[20:16]];
        sImm    = {{16{instr[15]}}, instr[15:0]};
        pcPlus4 = mPc + 32'd4;
        expPc        = mPc;
        expRegWrEn   = 1'b0;
        expRegWrAddr = instr[20:16];
        expRegWrData = '0;
        expMemWrEn   = 1'b0;
        expMemAddr   = rsV + sImm;
        expMemWrData = rtV;
        expNextPc    = pcPlus4;
        case (instr[31:26])
            `OP_RTYPE: begin
                expRegWrAddr = instr[15:11];
                case (instr[5:0])
                    `FN_ADD: begin
                        expRegWrEn   = 1'b1;
                        expRegWrData = rsV + rtV;
                    end
                    `FN_SUB: begin
                        expRegWrEn   = 1'b1;
                        expRegWrData = rsV - rtV;
                    end
                    `FN_SLT: begin
                        expRegWrEn   = 1'b1;
                        expRegWrData = {31'd0, $signed(rsV) < $signed(rtV)};
                    end
                    `FN_JR:  expNextPc = rsV;
                    default: ;
                endcase
            end
            `OP_XORI: begin
                expRegWrEn   = 1'b1;
                expRegWrData = rsV ^ {16'd0, instr[15:0]};
            end
            `OP_LW: begin
                expRegWrEn   = 1'b1;
                expRegWrData = mMem[expMemAddr[DAW+1:2]];
            end
            `OP_SW:  expMemWrEn = 1'b1;
            `OP_BNE: begin
                if (rsV != rtV) begin
                    expNextPc = pcPlus4 + {sImm[29:0], 2'b00};
                end
            end
            `OP_J:   expNextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
            `OP_JAL: begin
                expRegWrEn   = 1'b1;
                expRegWrAddr = `LINK_REG;
                expRegWrData = pcPlus4;
                expNextPc    = {pcPlus4[31:28], instr[25:0], 2'b00};
            end
            default: ;
        endcase
    end

    always @(posedge clk) begin
        if (!rstN) begin
            mPc <= '0;
            for (int i = 0; i < 32; i++) begin
                mRegs[i] <= '0;
            end
        end else begin
            if (expRegWrEn && expRegWrAddr != 5'd0) begin
                mRegs[expRegWrAddr] <= expRegWrData;
            end
            if (expMemWrEn) begin
                mMem[expMemAddr[DAW+1:2]] <= expMemWrData;
            end
            mPc     <= expNextPc;
            retired <= retired + 1;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the core did not reach its final loop within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int failures;
        rstN     = 1'b0;
        progWrEn = 1'b0;
        progAddr = '0;
        progData = '0;
        void'($urandom(32'hac30_79fb));
        buildProgram();
        loadProgram();
        repeat (RESET_CYCLES) @(negedge clk);
        rstN = 1'b1;
        while (pc != 32'(LOOP_PC)) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);     // A few laps of the final loop
        failures = DUT.chk.errorCount;
        $display("Summary: %0d assertion failures, %0d instructions retired",
                 failures, retired);
        if (failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+include
logic/mipsPkg.sv
logic/controlDecoder.sv
logic/alu.sv
logic/regFile.sv
logic/wordMemory.sv
logic/mipsCore.sv
bench/mipsCore_sva.sv
bench/mipsCore_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the fail message
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module mipsCore_tb -f list.f -o simv

# Keep the run going after the first assertion error so the summary line is printed
./obj_dir/simv +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failure"
